// File: hdl/router_cfg_pkg.sv
// Router sizing constants and types. Port numbers are 3 bits wide, so at most
// MAX_PORTS ports can be built. The grant vectors keep that full width whatever the port count.

package router_cfg_pkg;

    //////////////////////////////////////////////////////////////////////////////
    // Sizing

    // Largest port count a header can address
    localparam int MAX_PORTS = 8;

    // Width of a port number
    localparam int PORT_IDX_W = 3;

    // Build defaults used by the top level
    localparam int DEFAULT_NUM_PORTS     = 4;
    localparam int DEFAULT_COUNTER_WIDTH = 16;

    //////////////////////////////////////////////////////////////////////////////
    // Types

    // Ingress or egress port number
    typedef logic [PORT_IDX_W-1:0] port_idx_t;

    // One-hot ingress select held by an egress port
    typedef logic [MAX_PORTS-1:0] grant_t;

endpackage

// File: hdl/stream_pkg.sv
// Stream beat formats for a fixed 32-bit lane.
// The first word of a packet is a route header. Any later word is raw payload.

package stream_pkg;

    //////////////////////////////////////////////////////////////////////////////
    // Lane geometry

    localparam int DATA_BYTES = 4;
    localparam int DATA_W     = DATA_BYTES * 8;

    //////////////////////////////////////////////////////////////////////////////
    // Word views

    // Header view with the egress field in the top bits
    typedef struct packed {
        router_cfg_pkg::port_idx_t egress_port;
        router_cfg_pkg::port_idx_t src_port;
        logic [1:0]                reserved;
        logic [7:0]                seq;
        logic [15:0]               tag;
    } route_hdr_t;

    // Same word read as payload or as header
    typedef union packed {
        logic [DATA_W-1:0] raw;
        route_hdr_t        hdr;
    } pkt_word_u;

    //////////////////////////////////////////////////////////////////////////////
    // Beats

    // Stream beat without ready
    typedef struct packed {
        pkt_word_u data;
        logic      tlast;
        logic      tvalid;
    } axis_beat_t;

    // Decoded beat carrying the packet route on every beat
    typedef struct packed {
        axis_beat_t                beat;
        router_cfg_pkg::port_idx_t egress_port;
        logic                      first;
        logic                      drop;
    } dec_beat_t;

endpackage

// File: hdl/ingress_decode.sv
// One register slot per ingress port. The header is the first beat after reset or after tlast.
// An egress field of NUM_PORTS or above marks every beat of that packet as drop.
`timescale 1ns/1ps

module ingress_decode #(
    parameter int NUM_PORTS = router_cfg_pkg::DEFAULT_NUM_PORTS
) (
    input  logic                   phys_port_clk_ifc,
    input  logic                   rst,
    input  stream_pkg::axis_beat_t ing       [NUM_PORTS],
    output logic [NUM_PORTS-1:0]   ing_ready,
    output stream_pkg::dec_beat_t  dec       [NUM_PORTS],
    input  logic [NUM_PORTS-1:0]   dec_ready
);

    import router_cfg_pkg::*;
    import stream_pkg::*;

    // Port count one bit wider than a header field so that 8 fits
    localparam logic [PORT_IDX_W:0] PORT_LIMIT = (PORT_IDX_W + 1)'(NUM_PORTS);

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port

        logic      in_pkt_q;
        logic      slot_vld_q;
        dec_beat_t slot_q;
        dec_beat_t slot_d;
        logic      ing_xfer;

        // Slot can refill in the cycle it empties
        assign ing_ready[p] = !slot_vld_q || dec_ready[p];
        assign ing_xfer     = ing[p].tvalid && ing_ready[p];

        //////////////////////////////////////////////////////////////////////////////
        // Header decode

        always_comb begin
            slot_d.beat  = ing[p];
            slot_d.first = !in_pkt_q;
            if (!in_pkt_q) begin
                slot_d.egress_port = ing[p].data.hdr.egress_port;
                slot_d.drop        = {1'b0, ing[p].data.hdr.egress_port} >= PORT_LIMIT;
            end else begin
                // Body beats reuse the route of the previous beat
                slot_d.egress_port = slot_q.egress_port;
                slot_d.drop        = slot_q.drop;
            end
        end

        //////////////////////////////////////////////////////////////////////////////
        // Slot registers

        always_ff @(posedge phys_port_clk_ifc) begin
            if (rst) begin
                in_pkt_q   <= 1'b0;
                slot_vld_q <= 1'b0;
            end else if (ing_xfer) begin
                in_pkt_q   <= !ing[p].tlast;
                slot_vld_q <= 1'b1;
            end else if (dec_ready[p]) begin
                slot_vld_q <= 1'b0;
            end
        end

        always_ff @(posedge phys_port_clk_ifc) begin
            if (ing_xfer) begin
                slot_q <= slot_d;
            end
        end

        always_comb begin
            dec[p]             = slot_q;
            dec[p].beat.tvalid = slot_vld_q;
        end

        // Slot must not change under a stalled beat
        a_dec_hold: assert property (
            @(posedge phys_port_clk_ifc) disable iff (rst)
            dec[p].beat.tvalid && !dec_ready[p] |=> dec[p].beat.tvalid && $stable(dec[p])
        ) else $error("ingress_decode: port %0d dec beat changed while stalled", p);

    end : g_port

endmodule

// File: hdl/egress_switch.sv
// Per-egress packet lock. An idle port grants the lowest ingress port whose header targets it.
// The port then holds that grant until the tlast beat is taken. Drop beats are consumed at once.
`timescale 1ns/1ps

module egress_switch #(
    parameter int NUM_PORTS = router_cfg_pkg::DEFAULT_NUM_PORTS
) (
    input  logic                   phys_port_clk_ifc,
    input  logic                   rst,
    input  stream_pkg::dec_beat_t  dec       [NUM_PORTS],
    output logic [NUM_PORTS-1:0]   dec_ready,
    output stream_pkg::axis_beat_t egr       [NUM_PORTS],
    input  logic [NUM_PORTS-1:0]   egr_ready
);

    import router_cfg_pkg::*;
    import stream_pkg::*;

    // Ingress select of each egress port, valid in the current cycle
    grant_t               sel      [NUM_PORTS];
    logic [NUM_PORTS-1:0] out_free;
    // Same selects seen per ingress port
    logic [NUM_PORTS-1:0] sel_col  [NUM_PORTS];

    //////////////////////////////////////////////////////////////////////////////
    // Egress ports

    for (genvar e = 0; e < NUM_PORTS; e++) begin : g_egr

        grant_t     hdr_req;
        grant_t     pkt_vld;
        grant_t     grant_q;
        logic       busy_q;
        logic       out_vld_q;
        axis_beat_t out_q;
        axis_beat_t beat_mux;
        logic       take;

        always_comb begin
            hdr_req = '0;
            pkt_vld = '0;
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (dec[i].beat.tvalid && !dec[i].drop
                        && dec[i].egress_port == port_idx_t'(e)) begin
                    pkt_vld[i] = 1'b1;
                    hdr_req[i] = dec[i].first;
                end
            end
        end

        // Lowest set bit of the header requests
        assign sel[e]      = busy_q ? grant_q : (hdr_req & (~hdr_req + grant_t'(1)));
        assign out_free[e] = !out_vld_q || egr_ready[e];
        assign take        = |(sel[e] & pkt_vld) && out_free[e];

        always_comb begin
            beat_mux = dec[0].beat;
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (sel[e][i]) begin
                    beat_mux = dec[i].beat;
                end
            end
        end

        // Lock opens again once tlast has left the slot
        always_ff @(posedge phys_port_clk_ifc) begin
            if (rst) begin
                busy_q    <= 1'b0;
                grant_q   <= '0;
                out_vld_q <= 1'b0;
            end else if (take) begin
                busy_q    <= !beat_mux.tlast;
                grant_q   <= sel[e];
                out_vld_q <= 1'b1;
            end else if (egr_ready[e]) begin
                out_vld_q <= 1'b0;
            end
        end

        always_ff @(posedge phys_port_clk_ifc) begin
            if (take) begin
                out_q <= beat_mux;
            end
        end

        always_comb begin
            egr[e]        = out_q;
            egr[e].tvalid = out_vld_q;
        end

        a_grant_onehot: assert property (
            @(posedge phys_port_clk_ifc) disable iff (rst)
            busy_q |-> $onehot(grant_q)
        ) else $error("egress_switch: port %0d locked grant %b not one-hot", e, grant_q);

        a_egr_hold: assert property (
            @(posedge phys_port_clk_ifc) disable iff (rst)
            egr[e].tvalid && !egr_ready[e] |=> egr[e].tvalid && $stable(egr[e])
        ) else $error("egress_switch: port %0d egr beat changed while stalled", e);

    end : g_egr

    //////////////////////////////////////////////////////////////////////////////
    // Ingress side ready

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_ing

        for (genvar e = 0; e < NUM_PORTS; e++) begin : g_col
            assign sel_col[i][e] = sel[e][i];
        end

        // Drops leave at once, routed beats when their egress slot can take them
        assign dec_ready[i] = (dec[i].beat.tvalid && dec[i].drop) || |(sel_col[i] & out_free);

        a_single_owner: assert property (
            @(posedge phys_port_clk_ifc) disable iff (rst)
            $onehot0(sel_col[i])
        ) else $error("egress_switch: ingress %0d selected by %b", i, sel_col[i]);

    end : g_ing

endmodule

// File: hdl/port_counters.sv
// Packet counters per port, counted on tlast transfers. They wrap at COUNTER_WIDTH.
// cnt_clear zeroes all three counters of a port and wins over an increment.
`timescale 1ns/1ps

module port_counters #(
    parameter int NUM_PORTS     = router_cfg_pkg::DEFAULT_NUM_PORTS,
    parameter int COUNTER_WIDTH = router_cfg_pkg::DEFAULT_COUNTER_WIDTH
) (
    input  logic                     phys_port_clk_ifc,
    input  logic                     rst,
    input  stream_pkg::axis_beat_t   ing       [NUM_PORTS],
    input  logic [NUM_PORTS-1:0]     ing_ready,
    input  stream_pkg::dec_beat_t    dec       [NUM_PORTS],
    input  logic [NUM_PORTS-1:0]     dec_ready,
    input  stream_pkg::axis_beat_t   egr       [NUM_PORTS],
    input  logic [NUM_PORTS-1:0]     egr_ready,
    input  logic [NUM_PORTS-1:0]     cnt_clear,
    output logic [COUNTER_WIDTH-1:0] ing_cnt   [NUM_PORTS],
    output logic [COUNTER_WIDTH-1:0] egr_cnt   [NUM_PORTS],
    output logic [COUNTER_WIDTH-1:0] drop_cnt  [NUM_PORTS]
);

    localparam int CNT_ING  = 0;
    localparam int CNT_EGR  = 1;
    localparam int CNT_DROP = 2;
    localparam int NUM_CNT  = 3;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port

        logic [NUM_CNT-1:0]       inc;
        logic [COUNTER_WIDTH-1:0] cnt_q [NUM_CNT];

        //////////////////////////////////////////////////////////////////////////////
        // Packet end events

        assign inc[CNT_ING]  = ing[p].tvalid && ing_ready[p] && ing[p].tlast;
        assign inc[CNT_EGR]  = egr[p].tvalid && egr_ready[p] && egr[p].tlast;
        // Drops are counted on the ingress port that received them
        assign inc[CNT_DROP] = dec[p].beat.tvalid && dec_ready[p]
                               && dec[p].drop && dec[p].beat.tlast;

        always_ff @(posedge phys_port_clk_ifc) begin
            if (rst) begin
                for (int k = 0; k < NUM_CNT; k++) begin
                    cnt_q[k] <= '0;
                end
            end else begin
                for (int k = 0; k < NUM_CNT; k++) begin
                    if (cnt_clear[p]) begin
                        cnt_q[k] <= '0;
                    end else if (inc[k]) begin
                        cnt_q[k] <= cnt_q[k] + COUNTER_WIDTH'(1);
                    end
                end
            end
        end

        assign ing_cnt[p]  = cnt_q[CNT_ING];
        assign egr_cnt[p]  = cnt_q[CNT_EGR];
        assign drop_cnt[p] = cnt_q[CNT_DROP];

    end : g_port

endmodule

// File: hdl/echo_router_top.sv
// Echo router top, one clock and a synchronous active-high reset.
// NUM_PORTS must lie between 2 and MAX_PORTS. Best-case ingress to egress latency is 2 cycles.
`timescale 1ns/1ps

module echo_router_top #(
    parameter int NUM_PORTS     = router_cfg_pkg::DEFAULT_NUM_PORTS,
    parameter int COUNTER_WIDTH = router_cfg_pkg::DEFAULT_COUNTER_WIDTH
) (
    input  logic                     phys_port_clk_ifc,
    input  logic                     rst,
    input  stream_pkg::axis_beat_t   ing       [NUM_PORTS],
    output logic [NUM_PORTS-1:0]     ing_ready,
    output stream_pkg::axis_beat_t   egr       [NUM_PORTS],
    input  logic [NUM_PORTS-1:0]     egr_ready,
    input  logic [NUM_PORTS-1:0]     cnt_clear,
    output logic [COUNTER_WIDTH-1:0] ing_cnt   [NUM_PORTS],
    output logic [COUNTER_WIDTH-1:0] egr_cnt   [NUM_PORTS],
    output logic [COUNTER_WIDTH-1:0] drop_cnt  [NUM_PORTS]
);

    import router_cfg_pkg::*;
    import stream_pkg::*;

    dec_beat_t            dec [NUM_PORTS];
    logic [NUM_PORTS-1:0] dec_ready;

    initial begin
        assert (NUM_PORTS >= 2 && NUM_PORTS <= MAX_PORTS)
            else $fatal(1, "echo_router_top: NUM_PORTS %0d out of range", NUM_PORTS);
    end

    //////////////////////////////////////////////////////////////////////////////
    // Decode, switch and counters

    ingress_decode #(
        .NUM_PORTS ( NUM_PORTS )
    ) ingress_decode_i (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst               ( rst               ),
        .ing               ( ing               ),
        .ing_ready         ( ing_ready         ),
        .dec               ( dec               ),
        .dec_ready         ( dec_ready         )
    );

    egress_switch #(
        .NUM_PORTS ( NUM_PORTS )
    ) egress_switch_i (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst               ( rst               ),
        .dec               ( dec               ),
        .dec_ready         ( dec_ready         ),
        .egr               ( egr               ),
        .egr_ready         ( egr_ready         )
    );

    // Observes the three handshakes only
    port_counters #(
        .NUM_PORTS     ( NUM_PORTS     ),
        .COUNTER_WIDTH ( COUNTER_WIDTH )
    ) port_counters_i (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst               ( rst               ),
        .ing               ( ing               ),
        .ing_ready         ( ing_ready         ),
        .dec               ( dec               ),
        .dec_ready         ( dec_ready         ),
        .egr               ( egr               ),
        .egr_ready         ( egr_ready         ),
        .cnt_clear         ( cnt_clear         ),
        .ing_cnt           ( ing_cnt           ),
        .egr_cnt           ( egr_cnt           ),
        .drop_cnt          ( drop_cnt          )
    );

endmodule

// File: verification/echo_router_tb.sv
// Testbench for echo_router_top with 4 ports and 16-bit counters. Concurrent assertions
// compare each egress beat with per-source, per-egress queues of the words that entered.
`timescale 1ns/1ps

module echo_router_tb;

    import stream_pkg::*;

    localparam int NUM_PORTS   = 4;
    localparam int CNT_W       = 16;
    localparam int DRAIN_LIMIT = 5000;

    logic                 phys_port_clk_ifc = 1'b0;
    logic                 rst;
    axis_beat_t           ing        [NUM_PORTS];
    logic [NUM_PORTS-1:0] ing_ready;
    axis_beat_t           egr        [NUM_PORTS];
    logic [NUM_PORTS-1:0] egr_ready;
    logic [NUM_PORTS-1:0] cnt_clear;
    logic [CNT_W-1:0]     ing_cnt    [NUM_PORTS];
    logic [CNT_W-1:0]     egr_cnt    [NUM_PORTS];
    logic [CNT_W-1:0]     drop_cnt   [NUM_PORTS];

    // Source words hold route, tlast and data
    // Expected words hold tlast and data
    logic [35:0]          send_q     [NUM_PORTS][$];
    logic [32:0]          exp_q      [NUM_PORTS*NUM_PORTS][$];
    logic [NUM_PORTS-1:0] exp_have;
    logic [32:0]          exp_word   [NUM_PORTS];
    logic [NUM_PORTS-1:0] in_pkt;
    int                   cur_src    [NUM_PORTS];
    axis_beat_t           egr_prev   [NUM_PORTS];
    logic [NUM_PORTS-1:0] hold_prev;
    logic                 rst_prev;
    logic [7:0]           seq_num    [NUM_PORTS];
    logic [CNT_W-1:0]     tally_ing  [NUM_PORTS];
    logic [CNT_W-1:0]     tally_egr  [NUM_PORTS];
    logic [CNT_W-1:0]     tally_drop [NUM_PORTS];
    logic                 cnt_check;
    logic                 bp_mode;
    logic [31:0]          lfsr_state;
    string                test_name;

    always #5 phys_port_clk_ifc = ~phys_port_clk_ifc;

    echo_router_top #(
        .NUM_PORTS     ( NUM_PORTS ),
        .COUNTER_WIDTH ( CNT_W     )
    ) dut_i (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst               ( rst               ),
        .ing               ( ing               ),
        .ing_ready         ( ing_ready         ),
        .egr               ( egr               ),
        .egr_ready         ( egr_ready         ),
        .cnt_clear         ( cnt_clear         ),
        .ing_cnt           ( ing_cnt           ),
        .egr_cnt           ( egr_cnt           ),
        .drop_cnt          ( drop_cnt          )
    );

    //////////////////////////////////////////////////////////////////////////////
    // Helpers

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic show_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
        $display("=== FAIL ===");
    endtask

    task automatic print_failure(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
    endtask

    // Header first and then 0 to 7 random payload words
    task automatic build_packet(input int src, input logic [2:0] route);
        int          len;
        logic [15:0] tag;
        logic [31:0] word;
        len  = int'(lfsr_bits(3)) + 1;
        tag  = 16'(lfsr_bits(16));
        word = {route, 3'(src), 2'b00, seq_num[src], tag};
        for (int i = 0; i < len; i++) begin
            if (i > 0) begin
                word = lfsr_bits(32);
            end
            send_q[src].push_back({route, (i == len - 1), word});
        end
        seq_num[src]   = seq_num[src] + 8'd1;
        tally_ing[src] = tally_ing[src] + 16'd1;
        if (int'(route) < NUM_PORTS) begin
            tally_egr[route] = tally_egr[route] + 16'd1;
        end else begin
            tally_drop[src] = tally_drop[src] + 16'd1;
        end
    endtask

    task automatic wait_drain();
        int   cycles;
        logic busy;
        cycles = 0;
        busy   = 1'b1;
        while (busy) begin
            @(negedge phys_port_clk_ifc);
            busy = 1'b0;
            for (int i = 0; i < NUM_PORTS; i++) begin
                busy = busy || (send_q[i].size() > 0);
            end
            for (int i = 0; i < NUM_PORTS * NUM_PORTS; i++) begin
                busy = busy || (exp_q[i].size() > 0);
            end
            cycles++;
            if (busy && cycles > DRAIN_LIMIT) begin
                print_failure($sformatf("%s: traffic did not drain in time", test_name));
                $fatal(1);
            end
        end
        // Decode register plus the cycle a drop is taken
        repeat (2) @(posedge phys_port_clk_ifc);
    endtask

    task automatic run_traffic(input string name, input int pkts, input logic bp,
                               input logic one_target);
        logic [2:0] target;
        logic [2:0] route;
        test_name = name;
        @(negedge phys_port_clk_ifc);
        bp_mode = bp;
        target  = 3'(lfsr_bits(2));
        for (int k = 0; k < pkts; k++) begin
            for (int src = 0; src < NUM_PORTS; src++) begin
                route = one_target ? target : 3'(lfsr_bits(3));
                build_packet(src, route);
            end
        end
        wait_drain();
    endtask

    task automatic pulse_count_check();
        @(posedge phys_port_clk_ifc);
        cnt_check <= 1'b1;
        @(posedge phys_port_clk_ifc);
        cnt_check <= 1'b0;
        @(negedge phys_port_clk_ifc);
    endtask

    //////////////////////////////////////////////////////////////////////////////
    // Drivers and scoreboard

    initial begin
        logic [35:0] entry;
        for (int p = 0; p < NUM_PORTS; p++) begin
            ing[p] <= '0;
        end
        forever begin
            @(posedge phys_port_clk_ifc);
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (!rst && ing[p].tvalid && ing_ready[p]) begin
                    entry = send_q[p].pop_front();
                    if (int'(entry[35:33]) < NUM_PORTS) begin
                        exp_q[p * NUM_PORTS + int'(entry[35:33])].push_back(entry[32:0]);
                    end
                end
                if (!rst && send_q[p].size() > 0) begin
                    entry = send_q[p][0];
                    ing[p] <= {entry[31:0], entry[32], 1'b1};
                end else begin
                    ing[p] <= '0;
                end
            end
        end
    end

    initial begin
        egr_ready <= '1;
        forever begin
            @(posedge phys_port_clk_ifc);
            egr_ready <= bp_mode ? NUM_PORTS'(lfsr_bits(NUM_PORTS)) : '1;
        end
    end

    initial begin
        rst_prev  <= 1'b0;
        hold_prev <= '0;
        forever begin
            @(posedge phys_port_clk_ifc);
            rst_prev <= rst;
            for (int e = 0; e < NUM_PORTS; e++) begin
                egr_prev[e]  <= egr[e];
                hold_prev[e] <= egr[e].tvalid && !egr_ready[e];
            end
        end
    end

    // Header names the source queue for the whole packet
    always @(posedge phys_port_clk_ifc) begin
        int src_idx;
        for (int e = 0; e < NUM_PORTS; e++) begin
            if (rst) begin
                in_pkt[e] = 1'b0;
            end else if (egr[e].tvalid && egr_ready[e]) begin
                src_idx = in_pkt[e] ? cur_src[e] : int'(egr[e].data.hdr.src_port);
                if (src_idx < NUM_PORTS && exp_q[src_idx * NUM_PORTS + e].size() > 0) begin
                    void'(exp_q[src_idx * NUM_PORTS + e].pop_front());
                end
                cur_src[e] = src_idx;
                in_pkt[e]  = !egr[e].tlast;
            end
        end
    end

    always @(negedge phys_port_clk_ifc) begin
        int src_idx;
        for (int e = 0; e < NUM_PORTS; e++) begin
            src_idx     = in_pkt[e] ? cur_src[e] : int'(egr[e].data.hdr.src_port);
            exp_have[e] = 1'b0;
            exp_word[e] = '0;
            if (src_idx < NUM_PORTS && exp_q[src_idx * NUM_PORTS + e].size() > 0) begin
                exp_have[e] = 1'b1;
                exp_word[e] = exp_q[src_idx * NUM_PORTS + e][0];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////////////
    // Checks

    for (genvar e = 0; e < NUM_PORTS; e++) begin : g_check

        a_known_beat: assert property (@(posedge phys_port_clk_ifc) disable iff (rst)
            egr[e].tvalid && egr_ready[e] |-> exp_have[e]
        ) else begin
            print_failure($sformatf("%s: egress %0d sent a beat with no packet pending for it",
                                    test_name, e));
            $fatal(1);
        end

        a_beat_value: assert property (@(posedge phys_port_clk_ifc) disable iff (rst)
            egr[e].tvalid && egr_ready[e] && exp_have[e]
                |-> {egr[e].tlast, egr[e].data.raw} == exp_word[e]
        ) else begin
            show_mismatch($sformatf("%s egress %0d", test_name, e), 64'(exp_word[e]),
                          64'({$sampled(egr[e].tlast), $sampled(egr[e].data.raw)}));
            $fatal(1);
        end

        // Stalled beat must not move
        a_stall_hold: assert property (@(posedge phys_port_clk_ifc) disable iff (rst)
            hold_prev[e] |-> egr[e] == egr_prev[e]
        ) else begin
            show_mismatch($sformatf("%s hold egress %0d", test_name, e),
                          64'($sampled(egr_prev[e])), 64'($sampled(egr[e])));
            $fatal(1);
        end

        a_counts: assert property (@(posedge phys_port_clk_ifc) disable iff (rst)
            cnt_check |-> {ing_cnt[e], egr_cnt[e], drop_cnt[e]}
                          == {tally_ing[e], tally_egr[e], tally_drop[e]}
        ) else begin
            show_mismatch($sformatf("%s port %0d", test_name, e),
                          64'({tally_ing[e], tally_egr[e], tally_drop[e]}),
                          64'({$sampled(ing_cnt[e]), $sampled(egr_cnt[e]),
                               $sampled(drop_cnt[e])}));
            $fatal(1);
        end

        // Idle outputs and zero counters with ready back once reset is gone
        a_reset_state: assert property (@(posedge phys_port_clk_ifc)
            rst_prev |-> !egr[e].tvalid && ing_cnt[e] == '0 && egr_cnt[e] == '0
                         && drop_cnt[e] == '0 && (rst || ing_ready[e])
        ) else begin
            show_mismatch($sformatf("reset port %0d", e), 64'(1),
                          64'({$sampled(egr[e].tvalid), $sampled(ing_cnt[e]),
                               $sampled(egr_cnt[e]), $sampled(drop_cnt[e]),
                               $sampled(rst) || $sampled(ing_ready[e])}));
            $fatal(1);
        end

    end : g_check

    //////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        lfsr_state = 32'h79060a7c;
        bp_mode    = 1'b0;
        test_name  = "reset";
        rst       <= 1'b1;
        cnt_clear <= '0;
        cnt_check <= 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            seq_num[p]    = '0;
            tally_ing[p]  = '0;
            tally_egr[p]  = '0;
            tally_drop[p] = '0;
        end
        repeat (2) @(posedge phys_port_clk_ifc);
        rst <= 1'b0;

        run_traffic("delivery", 6, 1'b0, 1'b0);
        run_traffic("backpressure", 8, 1'b1, 1'b0);
        run_traffic("contention", 5, 1'b1, 1'b1);

        test_name = "counters";
        pulse_count_check();

        test_name = "counter clear";
        @(posedge phys_port_clk_ifc);
        cnt_clear[1] <= 1'b1;
        @(posedge phys_port_clk_ifc);
        cnt_clear <= '0;
        tally_ing[1]  = '0;
        tally_egr[1]  = '0;
        tally_drop[1] = '0;
        pulse_count_check();

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: project.f
hdl/router_cfg_pkg.sv
hdl/stream_pkg.sv
hdl/ingress_decode.sv
hdl/egress_switch.sv
hdl/port_counters.sv
hdl/echo_router_top.sv
verification/echo_router_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the echo router testbench, the exit status gives pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module echo_router_tb -f project.f \
    -o echo_router_sim &&
./obj_dir/echo_router_sim || exit 1
